/* ex_consts.svh */
/*
 * Execute stage constants
 * Data path width, register address width and divider step count
 */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Integer data path width
`define EX_XLEN 32

// Register file address width, upper half reserved for FP registers
`define EX_RADDR_W 6

// One restoring step per quotient bit
`define EX_DIV_STEPS 32

`endif

/* ex_pkg.sv */
/*
 * Execute stage types
 * Operation and state enums, unit requests and register write ports
 */
`include "ex_consts.svh"

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU operations, the divide group sits at the end
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU,
    ALU_DIV,
    ALU_DIVU,
    ALU_REM,
    ALU_REMU
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    MULT_MUL,
    MULT_MULH,
    MULT_MULHU,
    MULT_MULHSU
  } mult_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Unit states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  typedef enum logic {
    MULT_FIRST,
    MULT_SECOND
  } mult_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Requests and write ports
  ////////////////////////////////////////////////////////////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    alu_op_e              op;
    logic [`EX_XLEN-1:0]  a;
    logic [`EX_XLEN-1:0]  b;
    logic [`EX_XLEN-1:0]  c;
  } ex_alu_req_t;

  typedef struct packed {
    mult_op_e             op;
    logic [`EX_XLEN-1:0]  a;
    logic [`EX_XLEN-1:0]  b;
  } ex_mult_req_t;

  // One register file write port
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } ex_wr_t;

endpackage

/* ex_div.sv */
/*
 * Iterative restoring divider
 * Signed and unsigned quotient and remainder, one bit per cycle
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_div import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  alu_op_e             op_i,
  input  logic [`EX_XLEN-1:0] dividend_i,
  input  logic [`EX_XLEN-1:0] divisor_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                done_o
);

  localparam int unsigned CNT_W = $clog2(`EX_DIV_STEPS);

  div_state_e          state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [`EX_XLEN-1:0] quo_q, rem_q, dvs_q;
  logic                neg_q_q, neg_r_q;

  logic                signed_op, rem_op;
  logic [`EX_XLEN-1:0] a_mag, b_mag;
  logic [`EX_XLEN:0]   rem_shift, diff;
  logic [`EX_XLEN-1:0] q_fix, r_fix;

  // Operation decode, ID holds op_i until the result leaves
  assign signed_op = (op_i == ALU_DIV) || (op_i == ALU_REM);
  assign rem_op    = (op_i == ALU_REM) || (op_i == ALU_REMU);

  // Operand magnitudes
  assign a_mag = (signed_op && dividend_i[`EX_XLEN-1]) ? -dividend_i : dividend_i;
  assign b_mag = (signed_op && divisor_i[`EX_XLEN-1])  ? -divisor_i  : divisor_i;

  // Restoring step: shift in next dividend bit, trial subtract
  assign rem_shift = {rem_q, quo_q[`EX_XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvs_q};

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            state_q <= DIV_RUN;
            cnt_q   <= CNT_W'(`EX_DIV_STEPS - 1);
          end
        end
        DIV_RUN: begin
          if (cnt_q == '0) begin
            state_q <= DIV_DONE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        DIV_DONE: begin
          // Hold result until the instruction leaves EX
          if (ex_ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && start_i) begin
      // Quotient register starts with the dividend, bits shift out at the top
      quo_q   <= a_mag;
      rem_q   <= '0;
      dvs_q   <= b_mag;
      // Divide by zero keeps the all ones quotient unsigned
      neg_q_q <= signed_op && (dividend_i[`EX_XLEN-1] ^ divisor_i[`EX_XLEN-1])
                 && (divisor_i != '0);
      // Remainder takes the dividend sign
      neg_r_q <= signed_op && dividend_i[`EX_XLEN-1];
    end else if (state_q == DIV_RUN) begin
      if (!diff[`EX_XLEN]) begin
        rem_q <= diff[`EX_XLEN-1:0];
        quo_q <= {quo_q[`EX_XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[`EX_XLEN-1:0];
        quo_q <= {quo_q[`EX_XLEN-2:0], 1'b0};
      end
    end
  end

  // Sign fix, overflow case falls out of the magnitude arithmetic
  assign q_fix    = neg_q_q ? -quo_q : quo_q;
  assign r_fix    = neg_r_q ? -rem_q : rem_q;
  assign result_o = rem_op ? r_fix : q_fix;
  assign done_o   = (state_q == DIV_DONE);

endmodule

/* ex_alu.sv */
/*
 * Integer ALU
 * Arithmetic, logic, shifts, compares and branch decision, divider underneath
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en_i,
  input  ex_alu_req_t         req_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o,
  output logic                ready_o
);

  logic [`EX_XLEN-1:0] add_res, sub_res;
  logic [`EX_XLEN-1:0] sll_res, srl_res, sra_res;
  logic [`EX_XLEN-1:0] div_res;
  logic [4:0]          shamt;
  logic                eq, lt_s, lt_u;
  logic                is_div, div_start, div_done;

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic and shifts
  ////////////////////////////////////////////////////////////////////////////

  assign add_res = req_i.a + req_i.b;
  assign sub_res = req_i.a - req_i.b;

  // Shift amount from low five bits of operand b
  assign shamt   = req_i.b[4:0];
  assign sll_res = req_i.a << shamt;
  assign srl_res = req_i.a >> shamt;
  assign sra_res = $unsigned($signed(req_i.a) >>> shamt);

  // Shared comparators for SLT and branches
  assign eq   = (req_i.a == req_i.b);
  assign lt_s = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u = (req_i.a < req_i.b);

  ////////////////////////////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////////////////////////////

  assign is_div = (req_i.op == ALU_DIV)  || (req_i.op == ALU_DIVU) ||
                  (req_i.op == ALU_REM)  || (req_i.op == ALU_REMU);
  assign div_start = en_i && is_div;

  ex_div u_ex_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .op_i       (req_i.op),
    .dividend_i (req_i.a),
    .divisor_i  (req_i.b),
    .ex_ready_i (ex_ready_i),
    .result_o   (div_res),
    .done_o     (div_done)
  );

  // Stall EX while a divide is in flight
  assign ready_o = !div_start || div_done;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_ADD:  result_o = add_res;
      ALU_SUB:  result_o = sub_res;
      ALU_AND:  result_o = req_i.a & req_i.b;
      ALU_OR:   result_o = req_i.a | req_i.b;
      ALU_XOR:  result_o = req_i.a ^ req_i.b;
      ALU_SLL:  result_o = sll_res;
      ALU_SRL:  result_o = srl_res;
      ALU_SRA:  result_o = sra_res;
      ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
      ALU_DIV,
      ALU_DIVU,
      ALU_REM,
      ALU_REMU: result_o = div_res;
      // Branch compares write nothing useful
      default:  result_o = '0;
    endcase
  end

  // Branch decision
  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_result_o = eq;
      ALU_NE:  cmp_result_o = !eq;
      ALU_LT:  cmp_result_o = lt_s;
      ALU_GE:  cmp_result_o = !lt_s;
      ALU_LTU: cmp_result_o = lt_u;
      ALU_GEU: cmp_result_o = !lt_u;
      default: cmp_result_o = 1'b0;
    endcase
  end

endmodule

/* ex_mult.sv */
/*
 * Integer multiplier
 * Low product in one cycle, high product registered and returned in two
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_mult import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en_i,
  input  ex_mult_req_t        req_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                multicycle_o,
  output logic                ready_o
);

  mult_state_e             state_q;
  logic [2*`EX_XLEN-1:0]   prod_q;

  logic                    is_high, high_first;
  logic                    sign_a, sign_b;
  logic [`EX_XLEN:0]       ext_a, ext_b;
  logic [2*`EX_XLEN+1:0]   prod_full;

  assign is_high = (req_i.op != MULT_MUL);

  // Signedness per operation, MULHSU has signed a and unsigned b
  assign sign_a = (req_i.op == MULT_MULH) || (req_i.op == MULT_MULHSU);
  assign sign_b = (req_i.op == MULT_MULH);

  // One extra bit covers all signed/unsigned mixes
  assign ext_a = {sign_a && req_i.a[`EX_XLEN-1], req_i.a};
  assign ext_b = {sign_b && req_i.b[`EX_XLEN-1], req_i.b};

  // Operands sign extended to the full product width, wrap gives the exact product
  // Low word is identical for any signedness
  assign prod_full = {{(`EX_XLEN+1){ext_a[`EX_XLEN]}}, ext_a}
                   * {{(`EX_XLEN+1){ext_b[`EX_XLEN]}}, ext_b};

  // First cycle of a high variant
  assign high_first = en_i && is_high && (state_q == MULT_FIRST);

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_FIRST;
    end else begin
      case (state_q)
        MULT_FIRST: begin
          if (high_first) begin
            state_q <= MULT_SECOND;
          end
        end
        MULT_SECOND: begin
          // Back to FIRST once the instruction leaves EX
          if (ex_ready_i) begin
            state_q <= MULT_FIRST;
          end
        end
        default: state_q <= MULT_FIRST;
      endcase
    end
  end

  // Partial product register
  always_ff @(posedge clk) begin
    if (high_first) begin
      prod_q <= prod_full[2*`EX_XLEN-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (state_q == MULT_SECOND) begin
      result_o = prod_q[2*`EX_XLEN-1:`EX_XLEN];
    end else begin
      result_o = prod_full[`EX_XLEN-1:0];
    end
  end

  assign multicycle_o = high_first;
  assign ready_o      = !high_first;

endmodule

/* ex_stage.sv */
/*
 * Execute stage
 * ALU and multiplier, forwarding write port, EX/WB register and stall logic
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage import ex_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,

  // ALU request from ID
  input  logic                   alu_en_i,
  input  ex_alu_req_t            alu_req_i,

  // Multiplier request from ID
  input  logic                   mult_en_i,
  input  ex_mult_req_t           mult_req_i,

  // CSR read data
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,

  // LSU side
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,

  input  logic                   branch_in_ex_i,

  // Forwarding write from ID
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,

  // Load write, passed through to WB
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,

  input  logic                   wb_ready_i,

  // Register file write ports
  output ex_wr_t                 fwd_wr_o,
  output ex_wr_t                 wb_wr_o,

  // Jump target and branch decision to IF
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,

  output logic                   mult_multicycle_o,

  // Pipeline handshake
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic [`EX_XLEN-1:0]    alu_result, mult_result;
  logic                   alu_cmp_result;
  logic                   alu_ready, mult_ready;
  logic                   units_ready;

  // EX/WB register
  logic                   wb_we_q;
  logic [`EX_RADDR_W-1:0] wb_waddr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_ex_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (alu_en_i),
    .req_i        (alu_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result),
    .ready_o      (alu_ready)
  );

  ex_mult u_ex_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  // Branch handling
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.c;

  ////////////////////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////////////////////

  // Forwarding port, CSR over multiplier over ALU
  always_comb begin
    fwd_wr_o.we    = regfile_alu_we_i;
    fwd_wr_o.waddr = regfile_alu_waddr_i;
    if (csr_access_i) begin
      fwd_wr_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fwd_wr_o.wdata = mult_result;
    end else if (alu_en_i) begin
      fwd_wr_o.wdata = alu_result;
    end else begin
      fwd_wr_o.wdata = '0;
    end
  end

  // Load write-back, data comes straight from the LSU
  assign wb_wr_o.we    = wb_we_q;
  assign wb_wr_o.waddr = wb_waddr_q;
  assign wb_wr_o.wdata = lsu_rdata_i;

  // Write enable, valid already implies WB is ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new, flush the old write out
      wb_we_q <= 1'b0;
    end
  end

  // Address captured only for a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stall logic
  ////////////////////////////////////////////////////////////////////////////

  assign units_ready = alu_ready && mult_ready && lsu_ready_ex_i && wb_ready_i;

  // Branch resolves in EX without WB, so it may always leave
  assign ex_ready_o = units_ready || branch_in_ex_i;

  // Valid independent of ready
  assign ex_valid_o = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && units_ready;

endmodule

/* tb_ex_stage.sv */
/*
 * Execute stage testbench
 * LFSR driven ALU, branch, multiply, divide and load traffic checked by assertions
 */
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_ex_stage import ex_pkg::*; ();

  localparam int          CLK_PERIOD  = 4;
  localparam int          N_OPS       = 160;
  // Every operation budgeted at worst case divide latency
  localparam int          WATCHDOG_NS = N_OPS * (`EX_DIV_STEPS + 4) * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS   = 32'hA300_0000;

  logic                   clk;
  logic                   rst_n;
  logic                   alu_en;
  ex_alu_req_t            alu_req;
  logic                   mult_en;
  ex_mult_req_t           mult_req;
  logic                   csr_access;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic                   lsu_en;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   lsu_ready;
  logic                   branch_in_ex;
  logic                   rf_alu_we;
  logic [`EX_RADDR_W-1:0] rf_alu_waddr;
  logic                   rf_we;
  logic [`EX_RADDR_W-1:0] rf_waddr;
  logic                   wb_ready;
  ex_wr_t                 fwd_wr;
  ex_wr_t                 wb_wr;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   branch_decision;
  logic                   mult_multicycle;
  logic                   ex_ready;
  logic                   ex_valid;

  // Model state and bookkeeping
  logic [31:0]            lfsr;
  logic [31:0]            exp_wdata;
  logic                   exp_cmp;
  int                     op_cycle;
  int                     err_count;
  int                     op_count;
  int                     test_num;
  logic                   div_active;
  logic                   mult_high;

  ex_stage u_ex_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en),
    .alu_req_i           (alu_req),
    .mult_en_i           (mult_en),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (rf_alu_we),
    .regfile_alu_waddr_i (rf_alu_waddr),
    .regfile_we_i        (rf_we),
    .regfile_waddr_i     (rf_waddr),
    .wb_ready_i          (wb_ready),
    .fwd_wr_o            (fwd_wr),
    .wb_wr_o             (wb_wr),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr    = (lfsr >> 1) ^ (bit_out ? LFSR_TAPS : 32'h0);
      val     = {val[30:0], bit_out};
    end
    return val;
  endfunction

  // Signed less-than from sign bits first
  function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // RISC-V divide rules, zero divisor and overflow first
  function automatic logic [31:0] div_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic               ovf;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        res;
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    sa  = a;
    sb  = b;
    res = 32'h0;
    if (b == 0) begin
      // All ones quotient, dividend as remainder
      res = (op == ALU_DIV || op == ALU_DIVU) ? 32'hFFFF_FFFF : a;
    end else if (ovf && op == ALU_DIV) begin
      res = a;
    end else if (ovf && op == ALU_REM) begin
      res = 32'h0;
    end else begin
      // Signed forms truncate toward zero, remainder takes the dividend sign
      case (op)
        ALU_DIV:  res = sa / sb;
        ALU_DIVU: res = a / b;
        ALU_REM:  res = sa % sb;
        ALU_REMU: res = a % b;
        default:  res = 32'h0;
      endcase
    end
    return res;
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      // Logical shift with sign bits filled in above
      ALU_SRA:  return (a >> b[4:0]) | ({32{a[31]}} << (5'd31 - b[4:0]));
      ALU_SLT:  return {31'b0, less_signed(a, b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_DIV,
      ALU_DIVU,
      ALU_REM,
      ALU_REMU: return div_model(op, a, b);
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic cmp_model(input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return less_signed(a, b);
      ALU_GE:  return !less_signed(a, b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // 64 bit product of extended operands, wraps correctly for all signs
  function automatic logic [31:0] mult_model(input mult_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = {{32{a[31] && (op == MULT_MULH || op == MULT_MULHSU)}}, a};
    b_ext = {{32{b[31] && (op == MULT_MULH)}}, b};
    prod  = a_ext * b_ext;
    return (op == MULT_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  // Forwarding priority CSR, multiplier, ALU
  task automatic set_expect();
    exp_wdata = csr_access ? csr_rdata :
                mult_en    ? mult_model(mult_req.op, mult_req.a, mult_req.b) :
                alu_en     ? alu_model(alu_req.op, alu_req.a, alu_req.b) : 32'h0;
    exp_cmp   = alu_en ? cmp_model(alu_req.op, alu_req.a, alu_req.b) : 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus drivers
  ////////////////////////////////////////////////////////////////////////////

  // Ready inputs and load data stay as the test left them
  task automatic drive_idle();
    alu_en       = 1'b0;
    alu_req      = '0;
    mult_en      = 1'b0;
    mult_req     = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    branch_in_ex = 1'b0;
    rf_alu_we    = 1'b0;
    rf_alu_waddr = '0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    set_expect();
  endtask

  // Hold the instruction until EX accepts it, sampled 1 ns after the falling edge
  task automatic run_op();
    logic accepted;
    set_expect();
    op_cycle = 0;
    op_count = op_count + 1;
    accepted = 1'b0;
    while (!accepted) begin
      #1;
      accepted = ex_ready;
      @(negedge clk);
      if (!accepted) begin
        op_cycle = op_cycle + 1;
      end
    end
    drive_idle();
  endtask

  task automatic alu_issue(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic branch);
    drive_idle();
    alu_en       = 1'b1;
    alu_req.op   = op;
    alu_req.a    = a;
    alu_req.b    = b;
    alu_req.c    = rand_bits(32);
    branch_in_ex = branch;
    rf_alu_we    = 1'b1;
    rf_alu_waddr = `EX_RADDR_W'(rand_bits(`EX_RADDR_W));
    run_op();
  endtask

  task automatic mult_issue(input mult_op_e op, input logic [31:0] a, input logic [31:0] b);
    drive_idle();
    mult_en      = 1'b1;
    mult_req.op  = op;
    mult_req.a   = a;
    mult_req.b   = b;
    rf_alu_we    = 1'b1;
    rf_alu_waddr = `EX_RADDR_W'(rand_bits(`EX_RADDR_W));
    run_op();
  endtask

  task automatic load_issue();
    drive_idle();
    lsu_en    = 1'b1;
    rf_we     = 1'b1;
    rf_waddr  = `EX_RADDR_W'(rand_bits(`EX_RADDR_W));
    lsu_rdata = rand_bits(32);
    run_op();
  endtask

  task automatic report_fail(input string msg, input logic [31:0] got,
                             input logic [31:0] expected);
    err_count = err_count + 1;
    $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, expected);
  endtask

  task automatic finish_test(input string name);
    test_num = test_num + 1;
    $display("Test %0d %s done at %0t, %0d errors so far", test_num, name, $time, err_count);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  assign div_active = alu_en && (alu_req.op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU});
  assign mult_high  = mult_en && (mult_req.op != MULT_MUL);

  a_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |-> fwd_wr.wdata == exp_wdata && fwd_wr.we == rf_alu_we
                 && fwd_wr.waddr == rf_alu_waddr)
    else report_fail("forwarding write port", fwd_wr.wdata, exp_wdata);

  a_cmp: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en |-> branch_decision == exp_cmp && jump_target == alu_req.c)
    else report_fail("branch decision or jump target", 32'(branch_decision), 32'(exp_cmp));

  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex |-> ex_ready)
    else report_fail("ready with branch in EX", 32'(ex_ready), 32'd1);

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready || !lsu_ready) && !branch_in_ex |-> !ex_valid && !ex_ready)
    else report_fail("valid or ready under back-pressure", 32'(ex_valid), 32'd0);

  // Multicycle flag only in the first cycle of a high product
  a_mult_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle == (mult_high && op_cycle == 0))
    else report_fail("multicycle flag", 32'(mult_multicycle), 32'(mult_high));

  a_mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
    mult_en && ex_valid |-> op_cycle == (mult_high ? 1 : 0))
    else report_fail("multiply latency", op_cycle, 32'(mult_high));

  a_div_stall: assert property (@(posedge clk) disable iff (!rst_n)
    div_active && op_cycle <= `EX_DIV_STEPS |-> !ex_ready && !ex_valid)
    else report_fail("divide left EX early", op_cycle, `EX_DIV_STEPS + 1);

  a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
    div_active && ex_valid |-> op_cycle == `EX_DIV_STEPS + 1)
    else report_fail("divide latency", op_cycle, `EX_DIV_STEPS + 1);

  // EX/WB register one cycle after a valid load
  a_wb_load: assert property (@(posedge clk) disable iff (!rst_n)
    $past(ex_valid && rf_we) |-> wb_wr.we && wb_wr.waddr == $past(rf_waddr)
                                 && wb_wr.wdata == lsu_rdata)
    else report_fail("load write-back port", 32'(wb_wr.waddr), 32'(wb_wr.we));

  a_wb_clear: assert property (@(posedge clk) disable iff (!rst_n)
    $past(!ex_valid && wb_ready) |-> !wb_wr.we)
    else report_fail("write-back enable after idle cycle", 32'(wb_wr.we), 32'd0);

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $past(!wb_ready) |-> wb_wr.we == $past(wb_wr.we) && wb_wr.waddr == $past(wb_wr.waddr))
    else report_fail("write-back port moved while stalled", 32'(wb_wr.waddr), 32'd0);

  a_reset: assert property (@(posedge clk)
    !rst_n |-> !wb_wr.we && !mult_multicycle)
    else report_fail("outputs during reset", 32'(wb_wr.we), 32'd0);

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a_val;
    lfsr      = 32'h728b_9eb2;
    err_count = 0;
    op_count  = 0;
    test_num  = 0;
    op_cycle  = 0;
    rst_n     = 1'b0;
    wb_ready  = 1'b1;
    lsu_ready = 1'b1;
    lsu_rdata = '0;
    drive_idle();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Every non-divide operation with random operands
    for (int i = 0; i < 16; i++) begin
      for (int n = 0; n < 4; n++) begin
        alu_issue(alu_op_e'(i), rand_bits(32), rand_bits(32), 1'b0);
      end
    end
    finish_test("random ALU operations");

    // Equal, greater, less, then sign split pair with WB stalled
    for (int i = int'(ALU_EQ); i <= int'(ALU_GEU); i++) begin
      a_val = rand_bits(32);
      alu_issue(alu_op_e'(i), a_val, a_val, 1'b1);
      alu_issue(alu_op_e'(i), a_val + 1, a_val, 1'b1);
      alu_issue(alu_op_e'(i), a_val, a_val + 1, 1'b1);
      alu_issue(alu_op_e'(i), 32'h0000_0001, 32'h8000_0000, 1'b1);
      wb_ready = 1'b0;
      alu_issue(alu_op_e'(i), 32'h8000_0000, 32'h0000_0001, 1'b1);
      wb_ready = 1'b1;
    end
    finish_test("branches");

    for (int i = 0; i < 4; i++) begin
      for (int n = 0; n < 3; n++) begin
        mult_issue(mult_op_e'(i), rand_bits(32), rand_bits(32));
      end
      mult_issue(mult_op_e'(i), 32'h8000_0000, 32'h8000_0000);
      mult_issue(mult_op_e'(i), 32'h8000_0000, 32'hFFFF_FFFF);
      mult_issue(mult_op_e'(i), 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      mult_issue(mult_op_e'(i), 32'h7FFF_FFFF, 32'h8000_0000);
    end
    // CSR read data beats an ALU result on the same cycle
    drive_idle();
    alu_en       = 1'b1;
    alu_req.op   = ALU_ADD;
    alu_req.a    = rand_bits(32);
    alu_req.b    = rand_bits(32);
    csr_access   = 1'b1;
    csr_rdata    = rand_bits(32);
    rf_alu_we    = 1'b1;
    rf_alu_waddr = `EX_RADDR_W'(rand_bits(`EX_RADDR_W));
    run_op();
    finish_test("multiplies and CSR priority");

    // Small divisors give long quotients, then zero divisor and overflow
    for (int i = int'(ALU_DIV); i <= int'(ALU_REMU); i++) begin
      alu_issue(alu_op_e'(i), rand_bits(32), rand_bits(32), 1'b0);
      alu_issue(alu_op_e'(i), rand_bits(32), rand_bits(12), 1'b0);
      alu_issue(alu_op_e'(i), 32'hFFFF_FF85, 32'h0000_0007, 1'b0);
      alu_issue(alu_op_e'(i), rand_bits(32), 32'h0, 1'b0);
      alu_issue(alu_op_e'(i), 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
    end
    finish_test("divides");

    // Back to back loads, then two idle cycles
    for (int n = 0; n < 2; n++) begin
      load_issue();
      load_issue();
      repeat (2) @(negedge clk);
    end
    finish_test("load write-back");

    // Stall an ADD behind a pending load write, first on WB, then on the LSU
    load_issue();
    alu_en       = 1'b1;
    alu_req.op   = ALU_ADD;
    alu_req.a    = rand_bits(32);
    alu_req.b    = rand_bits(32);
    rf_alu_we    = 1'b1;
    wb_ready     = 1'b0;
    set_expect();
    repeat (3) @(negedge clk);
    wb_ready  = 1'b1;
    lsu_ready = 1'b0;
    repeat (2) @(negedge clk);
    lsu_ready = 1'b1;
    run_op();
    // Reset with a write pending in the EX/WB register
    load_issue();
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    finish_test("back-pressure and reset");

    $display("Summary: %0d tests, %0d operations, %0d errors", test_num, op_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the stage stopped accepting work", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
ex_pkg.sv
ex_div.sv
ex_alu.sv
ex_mult.sv
ex_stage.sv
tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_ex_stage

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_ex_stage \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF '** FAIL **' "$LOG_FILE"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
